/* hdl/fftPkg.sv */
`default_nettype none

package fftPkg;

    ////////////////////////////////////////////////////////////////////////////
    // transform geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int FFT_POINTS  = 16;
    localparam int FFT_STAGES  = 4;
    localparam int HALF_POINTS = 8;
    localparam int ADDR_W      = 4;
    localparam int SAMPLE_W    = 16;
    localparam int FRAME_W     = 512;
    localparam int TAG_W       = 18;

    localparam int STAGE_W   = $clog2(FFT_STAGES);
    localparam int GROUP_W   = $clog2(HALF_POINTS);
    localparam int TWIDDLE_W = $clog2(HALF_POINTS);

    localparam logic [ADDR_W-1:0]  LAST_SAMPLE = ADDR_W'(FFT_POINTS - 1);
    localparam logic [STAGE_W-1:0] LAST_STAGE  = STAGE_W'(FFT_STAGES - 1);
    localparam logic [GROUP_W-1:0] LAST_GROUP  = GROUP_W'(HALF_POINTS - 1);

    ////////////////////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////////////////////
    // imaginary part in the upper half
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] im;
        logic signed [SAMPLE_W-1:0] re;
    } complexSample;

    typedef struct packed {
        complexSample a;
        complexSample b;
    } butterflyPair;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        UNLOAD_WAIT,
        UNLOAD,
        FINISH
    } ctrlState;

endpackage

`default_nettype wire

/* hdl/twiddleRom.sv */
`timescale 1ns/1ps
`default_nettype none

module twiddleRom
    import fftPkg::*;
(
    input  logic [TWIDDLE_W-1:0] twiddleIndex,
    input  logic                 isIFFT,
    output complexSample         twiddle
);

    complexSample base;

    // W_k = cos(2*pi*k/16) - j*sin(2*pi*k/16), scaled by 32767
    always_comb begin
        case (twiddleIndex)
            3'd0:    base = '{re: 16'sd32767,  im: 16'sd0};
            3'd1:    base = '{re: 16'sd30273,  im: -16'sd12539};
            3'd2:    base = '{re: 16'sd23170,  im: -16'sd23170};
            3'd3:    base = '{re: 16'sd12539,  im: -16'sd30273};
            3'd4:    base = '{re: 16'sd0,      im: -16'sd32767};
            3'd5:    base = '{re: -16'sd12539, im: -16'sd30273};
            3'd6:    base = '{re: -16'sd23170, im: -16'sd23170};
            default: base = '{re: -16'sd30273, im: -16'sd12539};
        endcase
    end

    // inverse transform uses the conjugate
    always_comb begin
        twiddle = base;
        if (isIFFT) begin
            twiddle.im = -base.im;
        end
    end

endmodule

`default_nettype wire

/* hdl/butterflyUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module butterflyUnit
    import fftPkg::*;
(
    input  butterflyPair operands,
    input  complexSample twiddle,
    output butterflyPair results
);

    logic signed [31:0] prodRR;
    logic signed [31:0] prodII;
    logic signed [31:0] prodRI;
    logic signed [31:0] prodIR;
    logic signed [16:0] pRe;
    logic signed [16:0] pIm;
    logic signed [16:0] sumRe;
    logic signed [16:0] sumIm;
    logic signed [16:0] difRe;
    logic signed [16:0] difIm;

    // B * W, each Q1.15 term truncated before summing
    assign prodRR = operands.b.re * twiddle.re;
    assign prodII = operands.b.im * twiddle.im;
    assign prodRI = operands.b.re * twiddle.im;
    assign prodIR = operands.b.im * twiddle.re;

    assign pRe = 17'(prodRR >>> 15) - 17'(prodII >>> 15);
    assign pIm = 17'(prodRI >>> 15) + 17'(prodIR >>> 15);

    // 17 bit sums, halved back into 16 bits
    assign sumRe = 17'(operands.a.re) + pRe;
    assign sumIm = 17'(operands.a.im) + pIm;
    assign difRe = 17'(operands.a.re) - pRe;
    assign difIm = 17'(operands.a.im) - pIm;

    assign results.a.re = sumRe[16:1];
    assign results.a.im = sumIm[16:1];
    assign results.b.re = difRe[16:1];
    assign results.b.im = difIm[16:1];

endmodule

`default_nettype wire

/* hdl/fftSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fftSequencer
    import fftPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    output logic [ADDR_W-1:0]    indexA,
    output logic [ADDR_W-1:0]    indexB,
    output logic [TWIDDLE_W-1:0] twiddleIndex,
    output logic                 computeDone
);

    logic [STAGE_W-1:0] stage;
    logic [GROUP_W-1:0] group;
    logic [ADDR_W-1:0]  span;
    logic [ADDR_W-1:0]  mask;
    logic [ADDR_W-1:0]  offset;

    // one butterfly per cycle, 8 per stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= '0;
            group <= '0;
        end else if (!run) begin
            stage <= '0;
            group <= '0;
        end else begin
            group <= group + 1'b1;
            if (group == LAST_GROUP) begin
                stage <= stage + 1'b1;
            end
        end
    end

    assign computeDone = run && (stage == LAST_STAGE) && (group == LAST_GROUP);

    ////////////////////////////////////////////////////////////////////////////
    // address generation
    ////////////////////////////////////////////////////////////////////////////
    assign span   = ADDR_W'(1) << stage;
    assign mask   = span - 1'b1;
    assign offset = ADDR_W'(group) & mask;

    // block base doubled, plus position inside the block
    assign indexA = ((ADDR_W'(group) & ~mask) << 1) | offset;
    assign indexB = indexA + span;

    // k = offset * 8 / span
    assign twiddleIndex = TWIDDLE_W'(offset << (LAST_STAGE - stage));

    aIndexOrder: assert property (
        @(posedge clk) disable iff (rst)
        run |-> (indexB > indexA)
    );

endmodule

`default_nettype wire

/* hdl/fftRam.sv */
`timescale 1ns/1ps
`default_nettype none

module fftRam
    import fftPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  ctrlState          state,
    input  logic [ADDR_W-1:0] loadCount,
    input  logic [ADDR_W-1:0] unloadCount,
    input  complexSample      loadSample,
    input  logic [ADDR_W-1:0] indexA,
    input  logic [ADDR_W-1:0] indexB,
    input  butterflyPair      results,
    output butterflyPair      operands,
    output complexSample      unloadSample
);

    complexSample      mem [FFT_POINTS];
    logic [ADDR_W-1:0] loadAddr;
    logic [ADDR_W-1:0] readAddrA;

    // input lands in bit-reversed order for in-place DIT
    assign loadAddr = {<<{loadCount}};

    // port A is shared by compute and unload
    assign readAddrA = (state == UNLOAD) ? unloadCount : indexA;

    assign operands.a   = mem[readAddrA];
    assign operands.b   = mem[indexB];
    assign unloadSample = mem[readAddrA];

    always_ff @(posedge clk) begin
        if (!rst) begin
            if (state == LOAD) begin
                mem[loadAddr] <= loadSample;
            end else if (state == COMPUTE) begin
                mem[indexA] <= results.a;
                mem[indexB] <= results.b;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fftControl.sv */
`timescale 1ns/1ps
`default_nettype none

module fftControl
    import fftPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              startF,
    input  logic              startI,
    input  logic [TAG_W-1:0]  sigNum,
    input  logic              frameReady,
    input  logic              outBusy,
    input  logic              computeDone,
    output ctrlState          state,
    output logic              isIFFT,
    output logic [ADDR_W-1:0] loadCount,
    output logic [ADDR_W-1:0] unloadCount,
    output logic              done,
    output logic              calculating,
    output logic [TAG_W-1:0]  sigNumMC
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            isIFFT      <= 1'b0;
            loadCount   <= '0;
            unloadCount <= '0;
            sigNumMC    <= '0;
        end else begin
            case (state)
                // starts are only taken here
                IDLE: begin
                    if (startF || startI) begin
                        state    <= LOAD;
                        sigNumMC <= sigNum;
                        isIFFT   <= startI;
                    end
                end
                LOAD: begin
                    if (frameReady) begin
                        loadCount <= loadCount + 1'b1;
                        if (loadCount == LAST_SAMPLE) begin
                            state <= COMPUTE;
                        end
                    end
                end
                COMPUTE: begin
                    if (computeDone) begin
                        state <= outBusy ? UNLOAD_WAIT : UNLOAD;
                    end
                end
                // previous result still unread
                UNLOAD_WAIT: begin
                    if (!outBusy) begin
                        state <= UNLOAD;
                    end
                end
                UNLOAD: begin
                    unloadCount <= unloadCount + 1'b1;
                    if (unloadCount == LAST_SAMPLE) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    sigNumMC <= '0;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign done        = (state == FINISH);
    assign calculating = (state != IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    aDonePulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

    // load must not run ahead of the input buffer
    aLoadHold: assert property (
        @(posedge clk) disable iff (rst)
        (state == LOAD && !frameReady) |=> (state == LOAD)
    );

endmodule

`default_nettype wire

/* hdl/frameBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frameBuffer
    import fftPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               loadInFifo,
    input  logic [FRAME_W-1:0] mcDataIn,
    input  ctrlState           state,
    input  logic [ADDR_W-1:0]  loadCount,
    input  logic [ADDR_W-1:0]  unloadCount,
    input  complexSample       unloadSample,
    input  logic               read,
    input  logic [TAG_W-1:0]   sigNumMC,
    output logic               inFifoReady,
    output complexSample       loadSample,
    output logic [FRAME_W-1:0] mcDataOut,
    output logic               mcDataOutValid,
    output logic [TAG_W-1:0]   mcTagOut
);

    complexSample [FFT_POINTS-1:0] inFrame;
    complexSample [FFT_POINTS-1:0] outFrame;
    logic                          inFull;
    logic                          outValid;

    ////////////////////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (loadInFifo && !inFull) begin
            inFrame <= mcDataIn;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inFull <= 1'b0;
        end else if (loadInFifo && !inFull) begin
            inFull <= 1'b1;
        end else if (state == LOAD && inFull && loadCount == LAST_SAMPLE) begin
            inFull <= 1'b0;
        end
    end

    assign inFifoReady = !inFull;
    assign loadSample  = inFrame[loadCount];

    ////////////////////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == UNLOAD) begin
            outFrame[unloadCount] <= unloadSample;
        end
    end

    // tag copied while sigNumMC still holds it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
            mcTagOut <= '0;
        end else if (state == UNLOAD && unloadCount == LAST_SAMPLE) begin
            outValid <= 1'b1;
            mcTagOut <= sigNumMC;
        end else if (read) begin
            outValid <= 1'b0;
        end
    end

    assign mcDataOut      = outFrame;
    assign mcDataOutValid = outValid;

    aNoOverwrite: assert property (
        @(posedge clk) disable iff (rst)
        (loadInFifo && inFull) |=> $stable(inFrame)
    );

endmodule

`default_nettype wire

/* hdl/fftAccel.sv */
`timescale 1ns/1ps
`default_nettype none

module fftAccel
    import fftPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               startF,
    input  logic               startI,
    input  logic               loadInFifo,
    input  logic               read,
    input  logic [TAG_W-1:0]   sigNum,
    input  logic [FRAME_W-1:0] mcDataIn,
    output logic               done,
    output logic               calculating,
    output logic               inFifoReady,
    output logic               mcDataOutValid,
    output logic [TAG_W-1:0]   sigNumMC,
    output logic [TAG_W-1:0]   mcTagOut,
    output logic [FRAME_W-1:0] mcDataOut
);

    ctrlState              state;
    logic                  isIFFT;
    logic                  computeDone;
    logic [ADDR_W-1:0]     loadCount;
    logic [ADDR_W-1:0]     unloadCount;
    logic [ADDR_W-1:0]     indexA;
    logic [ADDR_W-1:0]     indexB;
    logic [TWIDDLE_W-1:0]  twiddleIndex;
    complexSample          twiddle;
    complexSample          loadSample;
    complexSample          unloadSample;
    butterflyPair          operands;
    butterflyPair          results;

    fftControl ctrl (
        .clk(clk), .rst(rst), .startF(startF), .startI(startI), .sigNum(sigNum),
        .frameReady(!inFifoReady), .outBusy(mcDataOutValid), .computeDone(computeDone),
        .state(state), .isIFFT(isIFFT), .loadCount(loadCount), .unloadCount(unloadCount),
        .done(done), .calculating(calculating), .sigNumMC(sigNumMC)
    );

    fftSequencer seq (
        .clk(clk), .rst(rst), .run(state == COMPUTE), .indexA(indexA), .indexB(indexB),
        .twiddleIndex(twiddleIndex), .computeDone(computeDone)
    );

    twiddleRom rom (.twiddleIndex(twiddleIndex), .isIFFT(isIFFT), .twiddle(twiddle));

    butterflyUnit bfly (.operands(operands), .twiddle(twiddle), .results(results));

    fftRam ram (
        .clk(clk), .rst(rst), .state(state), .loadCount(loadCount),
        .unloadCount(unloadCount), .loadSample(loadSample), .indexA(indexA),
        .indexB(indexB), .results(results), .operands(operands),
        .unloadSample(unloadSample)
    );

    frameBuffer buffers (
        .clk(clk), .rst(rst), .loadInFifo(loadInFifo), .mcDataIn(mcDataIn),
        .state(state), .loadCount(loadCount), .unloadCount(unloadCount),
        .unloadSample(unloadSample), .read(read), .sigNumMC(sigNumMC),
        .inFifoReady(inFifoReady), .loadSample(loadSample), .mcDataOut(mcDataOut),
        .mcDataOutValid(mcDataOutValid), .mcTagOut(mcTagOut)
    );

endmodule

`default_nettype wire

/* sim/fftChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module fftChecker
    import fftPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               done,
    input  logic               calculating,
    input  logic               inFifoReady,
    input  logic               loadInFifo,
    input  logic               mcDataOutValid,
    input  logic [TAG_W-1:0]   sigNumMC,
    input  logic [TAG_W-1:0]   mcTagOut,
    input  logic [FRAME_W-1:0] mcDataOut,
    input  logic               expPush,
    input  logic [FRAME_W-1:0] expFrame,
    input  logic [TAG_W-1:0]   expTag,
    input  logic               expInverse,
    output int                 errorCount,
    output int                 resultCount
);

    logic [FRAME_W-1:0] frameQ[$];
    logic [TAG_W-1:0]   tagQ[$];
    logic               inverseQ[$];
    logic               prevValid = 1'b0;
    logic               prevDone = 1'b0;
    logic               prevWrite = 1'b0;
    logic               resetChecked = 1'b0;
    int                 errors = 0;
    int                 results = 0;

    assign errorCount  = errors;
    assign resultCount = results;

    task automatic reportError(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    // outputs are settled half a cycle after the rising edge
    always @(negedge clk) begin
        logic [FRAME_W-1:0] wantFrame;
        logic [TAG_W-1:0]   wantTag;
        logic               wantInv;
        int                 bad;
        if (rst) begin
            if (!resetChecked) begin
                resetChecked = 1'b1;
                if (done || calculating || mcDataOutValid || sigNumMC != '0 ||
                    mcTagOut != '0 || !inFifoReady) begin
                    reportError("outputs not at their reset values");
                end else begin
                    $display("reset values: ok");
                end
            end
        end else begin
            if (expPush) begin
                frameQ.push_back(expFrame);
                tagQ.push_back(expTag);
                inverseQ.push_back(expInverse);
            end
            if (prevWrite && inFifoReady) begin
                reportError("inFifoReady still high after a frame write");
            end
            if (prevDone && sigNumMC != '0) begin
                reportError("sigNumMC not cleared after done");
            end
            if (prevDone && calculating) begin
                reportError("calculating still high after done");
            end
            if (done && prevValid) begin
                reportError("done while the previous result was unread");
            end

            ////////////////////////////////////////////////////////////////////////////
            // new result on the output port
            ////////////////////////////////////////////////////////////////////////////
            if (mcDataOutValid && !prevValid) begin
                if (!done) begin
                    reportError("result appeared without a done pulse");
                end
                if (frameQ.size() == 0) begin
                    reportError("result with no expected frame");
                end else begin
                    wantFrame = frameQ.pop_front();
                    wantTag   = tagQ.pop_front();
                    wantInv   = inverseQ.pop_front();
                    results++;
                    bad = 0;
                    for (int k = 0; k < FFT_POINTS; k++) begin
                        if (mcDataOut[32*k +: 32] != wantFrame[32*k +: 32]) begin
                            bad++;
                        end
                    end
                    if (bad != 0) begin
                        reportError($sformatf("frame %0d has %0d wrong samples", results, bad));
                    end
                    if (mcTagOut != wantTag) begin
                        reportError($sformatf("frame %0d tag %05h, expected %05h",
                                              results, mcTagOut, wantTag));
                    end
                    $display("frame %0d %s tag %05h: %s", results, wantInv ? "IFFT" : "FFT",
                             wantTag, (bad == 0 && mcTagOut == wantTag) ? "ok" : "mismatch");
                end
            end
            prevWrite = loadInFifo && inFifoReady;
            prevDone  = done;
            prevValid = mcDataOutValid;
        end
    end

endmodule

`default_nettype wire

/* sim/tbFftAccel.sv */
`timescale 1ns/1ps
`default_nettype none

module tbFftAccel import fftPkg::*; ();

    localparam real PI     = 3.14159265358979;
    localparam int  NORMAL = 0;
    localparam int  EARLY  = 1;
    localparam int  DOUBLE = 2;
    localparam int  EXTRA  = 3;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               startF;
    logic               startI;
    logic               loadInFifo;
    logic               read;
    logic [TAG_W-1:0]   sigNum;
    logic [FRAME_W-1:0] mcDataIn;
    logic               done;
    logic               calculating;
    logic               inFifoReady;
    logic               mcDataOutValid;
    logic [TAG_W-1:0]   sigNumMC;
    logic [TAG_W-1:0]   mcTagOut;
    logic [FRAME_W-1:0] mcDataOut;

    logic               expPush;
    logic [FRAME_W-1:0] expFrame;
    logic [TAG_W-1:0]   expTag;
    logic               expInverse;
    int                 errorCount;
    int                 resultCount;

    logic [31:0]        rngState;
    int                 twRe [8];
    int                 twIm [8];
    int                 readDelay [64];
    logic               aborted = 1'b0;
    logic               finished = 1'b0;
    int                 pushedCount;
    logic [FRAME_W-1:0] lastForward;

    always #4 clk = ~clk;

    fftAccel UUT (
        .clk(clk), .rst(rst), .startF(startF), .startI(startI), .loadInFifo(loadInFifo),
        .read(read), .sigNum(sigNum), .mcDataIn(mcDataIn), .done(done),
        .calculating(calculating), .inFifoReady(inFifoReady),
        .mcDataOutValid(mcDataOutValid), .sigNumMC(sigNumMC), .mcTagOut(mcTagOut),
        .mcDataOut(mcDataOut)
    );

    fftChecker resultCheck (
        .clk(clk), .rst(rst), .done(done), .calculating(calculating),
        .inFifoReady(inFifoReady), .loadInFifo(loadInFifo),
        .mcDataOutValid(mcDataOutValid), .sigNumMC(sigNumMC), .mcTagOut(mcTagOut),
        .mcDataOut(mcDataOut), .expPush(expPush), .expFrame(expFrame), .expTag(expTag),
        .expInverse(expInverse), .errorCount(errorCount), .resultCount(resultCount)
    );

    ////////////////////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [FRAME_W-1:0] randomFrame();
        logic [FRAME_W-1:0] f;
        for (int k = 0; k < FFT_POINTS; k++) begin
            f[32*k +: 32] = nextRand();
        end
        return f;
    endfunction

    function automatic int roundQ(input real v);
        if (v >= 0.0) begin
            return $rtoi(v + 0.5);
        end
        return -$rtoi(0.5 - v);
    endfunction

    // in-place radix-2 DIT, every butterfly halved
    function automatic logic [FRAME_W-1:0] fftModel(input logic [FRAME_W-1:0] x,
                                                    input logic inverse);
        logic signed [15:0] re [16];
        logic signed [15:0] im [16];
        logic signed [15:0] wr;
        logic signed [15:0] wi;
        logic signed [31:0] mRR;
        logic signed [31:0] mII;
        logic signed [31:0] mRI;
        logic signed [31:0] mIR;
        logic signed [16:0] pr;
        logic signed [16:0] pi;
        logic signed [16:0] sRe;
        logic signed [16:0] sIm;
        logic signed [16:0] dRe;
        logic signed [16:0] dIm;
        logic [3:0]         rev;
        logic [3:0]         ia;
        logic [3:0]         ib;
        logic [2:0]         t;
        logic [FRAME_W-1:0] y;
        int                 span;
        for (int k = 0; k < FFT_POINTS; k++) begin
            rev = {k[0], k[1], k[2], k[3]};
            re[rev] = x[32*k +: 16];
            im[rev] = x[32*k+16 +: 16];
        end
        for (int s = 0; s < FFT_STAGES; s++) begin
            span = 1 << s;
            for (int g = 0; g < HALF_POINTS; g++) begin
                ia = 4'((g / span) * 2 * span + g % span);
                ib = ia + 4'(span);
                t  = 3'((g % span) * 8 / span);
                wr = 16'(twRe[t]);
                wi = inverse ? 16'(-twIm[t]) : 16'(twIm[t]);
                mRR = 32'(re[ib]) * 32'(wr);
                mII = 32'(im[ib]) * 32'(wi);
                mRI = 32'(re[ib]) * 32'(wi);
                mIR = 32'(im[ib]) * 32'(wr);
                pr  = 17'(mRR >>> 15) - 17'(mII >>> 15);
                pi  = 17'(mRI >>> 15) + 17'(mIR >>> 15);
                sRe = 17'(re[ia]) + pr;
                sIm = 17'(im[ia]) + pi;
                dRe = 17'(re[ia]) - pr;
                dIm = 17'(im[ia]) - pi;
                re[ia] = sRe[16:1];
                im[ia] = sIm[16:1];
                re[ib] = dRe[16:1];
                im[ib] = dIm[16:1];
            end
        end
        for (int k = 0; k < FFT_POINTS; k++) begin
            y[32*k +: 16]    = re[k];
            y[32*k+16 +: 16] = im[k];
        end
        return y;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bus tasks, all entered and left 1 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitInReady();
        int n = 0;
        while (!inFifoReady && n < 500) begin
            cycles(1);
            n++;
        end
        if (!inFifoReady) begin
            $display("timeout: input buffer never became free");
            aborted = 1'b1;
        end
    endtask

    task automatic waitIdle();
        int n = 0;
        while (calculating && n < 500) begin
            cycles(1);
            n++;
        end
        if (calculating) begin
            $display("timeout: accelerator never returned to idle");
            aborted = 1'b1;
        end
    endtask

    task automatic waitResults();
        int n = 0;
        while (resultCount < pushedCount && !aborted && n < 500) begin
            cycles(1);
            n++;
        end
        if (resultCount < pushedCount) begin
            $display("timeout: not all expected results arrived");
            aborted = 1'b1;
        end
    endtask

    task automatic writeFrame(input logic [FRAME_W-1:0] frame);
        loadInFifo = 1'b1;
        mcDataIn   = frame;
        cycles(1);
        loadInFifo = 1'b0;
    endtask

    task automatic issueStart(input logic [TAG_W-1:0] tag, input logic inverse,
                              input logic expected, input logic [FRAME_W-1:0] model);
        startF     = !inverse;
        startI     = inverse;
        sigNum     = tag;
        expPush    = expected;
        expFrame   = model;
        expTag     = tag;
        expInverse = inverse;
        if (expected) begin
            pushedCount++;
        end
        cycles(1);
        startF  = 1'b0;
        startI  = 1'b0;
        expPush = 1'b0;
    endtask

    task automatic runFrame(input logic [FRAME_W-1:0] frame, input logic [TAG_W-1:0] tag,
                            input logic inverse, input int mode);
        logic [FRAME_W-1:0] model;
        logic [FRAME_W-1:0] junk;
        int                 gap;
        if (aborted) begin
            return;
        end
        model = fftModel(frame, inverse);
        if (!inverse) begin
            lastForward = model;
        end
        junk = randomFrame();
        gap  = int'(nextRand() % 32'd8);
        waitInReady();
        if (aborted) begin
            return;
        end
        if (mode == EARLY) begin
            // start first, frame follows later
            waitIdle();
            if (aborted) begin
                return;
            end
            issueStart(tag, inverse, 1'b1, model);
            cycles(gap + 2);
            writeFrame(frame);
        end else begin
            writeFrame(frame);
            if (mode == DOUBLE) begin
                writeFrame(junk);
            end
            waitIdle();
            if (aborted) begin
                return;
            end
            cycles(gap);
            issueStart(tag, inverse, 1'b1, model);
            if (mode == EXTRA) begin
                cycles(gap + 1);
                issueStart(18'(nextRand()), !inverse, 1'b0, junk);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output reader with random back-pressure
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int idx;
        int n;
        idx  = 0;
        read = 1'b0;
        n    = 0;
        // outputs are only meaningful once reset is released
        while (rst && n < 500) begin
            cycles(1);
            n++;
        end
        while (!finished && !aborted) begin
            n = 0;
            while (!mcDataOutValid && !finished && n < 500) begin
                cycles(1);
                n++;
            end
            if (n >= 500) begin
                $display("timeout: no result appeared within 500 cycles");
                aborted = 1'b1;
            end else if (mcDataOutValid) begin
                cycles(readDelay[idx % 64]);
                read = 1'b1;
                cycles(1);
                read = 1'b0;
                idx++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        startF      = 1'b0;
        startI      = 1'b0;
        loadInFifo  = 1'b0;
        sigNum      = '0;
        mcDataIn    = '0;
        expPush     = 1'b0;
        expFrame    = '0;
        expTag      = '0;
        expInverse  = 1'b0;
        pushedCount = 0;
        lastForward = '0;
        rngState    = 32'hfe35;
        for (int k = 0; k < 8; k++) begin
            twRe[k] = roundQ(32767.0 * $cos(2.0 * PI * k / 16.0));
            twIm[k] = -roundQ(32767.0 * $sin(2.0 * PI * k / 16.0));
        end
        for (int i = 0; i < 64; i++) begin
            readDelay[i] = int'(nextRand() % 32'd61);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 20; i++) begin
            runFrame(randomFrame(), 18'(nextRand()), 1'b0, NORMAL);
        end
        for (int i = 0; i < 8; i++) begin
            runFrame(randomFrame(), 18'(nextRand()), 1'b1, NORMAL);
        end
        // a forward result goes back in as IFFT input
        runFrame(lastForward, 18'(nextRand()), 1'b1, NORMAL);
        for (int m = EARLY; m <= EXTRA; m++) begin
            for (int i = 0; i < 4; i++) begin
                r = nextRand();
                runFrame(randomFrame(), 18'(nextRand()), r[0], m);
            end
        end

        waitResults();
        if (!aborted) begin
            cycles(150);
        end
        finished = 1'b1;
        $display("results: %0d of %0d checked, %0d errors", resultCount, pushedCount,
                 errorCount);
        if (!aborted && errorCount == 0 && resultCount == pushedCount) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/fftPkg.sv
hdl/twiddleRom.sv
hdl/butterflyUnit.sv
hdl/fftSequencer.sv
hdl/fftRam.sv
hdl/fftControl.sv
hdl/frameBuffer.sv
hdl/fftAccel.sv
sim/fftChecker.sv
sim/tbFftAccel.sv

/* run.sh */
#!/bin/sh
# build and run the FFT accelerator testbench with Verilator
set -e

verilator --binary --timing --assert --top-module tbFftAccel \
    -f vlog.f --Mdir obj_dir -o simv

./obj_dir/simv > sim.log
cat sim.log

# fails the script unless the pass line is present
grep -q "TESTS PASSED" sim.log
